/* spi_pkg.sv */
`default_nettype none

package spi_pkg;

  // bus widths
  localparam int addr_w    = 32;
  localparam int data_w    = 32;
  localparam int rb_addr_w = 5;    // register bus offset
  localparam int div_w     = 8;    // serial clock divider

  // rxd and txd share their register slots
  localparam logic [rb_addr_w-1:0] reg_rxd0 = 5'h00;
  localparam logic [rb_addr_w-1:0] reg_rxd1 = 5'h04;
  localparam logic [rb_addr_w-1:0] reg_txd0 = 5'h00;
  localparam logic [rb_addr_w-1:0] reg_txd1 = 5'h04;
  localparam logic [rb_addr_w-1:0] reg_ctl  = 5'h10;
  localparam logic [rb_addr_w-1:0] reg_div  = 5'h14;
  localparam logic [rb_addr_w-1:0] reg_cs   = 5'h18;

  // ctl bit positions
  localparam int ctl_char_len   = 0;    // lsb of length field
  localparam int ctl_char_len_w = 7;    // 0 means 64 bits
  localparam int ctl_go         = 8;
  localparam int ctl_rx_neg     = 9;
  localparam int ctl_tx_neg     = 10;
  localparam int ctl_lsb        = 11;
  localparam int ctl_ie         = 12;
  localparam int ctl_ass        = 13;
  localparam int ctl_rd_endian  = 14;
  localparam int ctl_cpol       = 15;

  localparam logic [7:0] flash_cmd_read = 8'h03;

  // 64 bit transfer, mode 0, auto cs, byte swapped result
  localparam logic [data_w-1:0] xip_ctl_word =
      (data_w'(1) << ctl_go) |
      (data_w'(1) << ctl_ie) |
      (data_w'(1) << ctl_ass) |
      (data_w'(1) << ctl_rd_endian) |
      (data_w'(1) << ctl_tx_neg);

  typedef enum logic [2:0] {
    idle,
    csr,        // plain register access
    wr_txd0,
    wr_txd1,
    wr_cs,
    wr_ctl,
    wait_irq,
    rd_rxd0
  } xip_state_t;

  typedef enum logic [1:0] {
    bus_idle,
    bus_setup,
    bus_access
  } bus_phase_t;

  typedef enum logic [1:0] {
    sh_idle,
    sh_run,
    sh_done
  } shift_state_t;

endpackage

`default_nettype wire

/* spi_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_shifter
  import spi_pkg::*;
(
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      start,
  input  logic [63:0]               tx_bits,
  input  logic [ctl_char_len_w-1:0] char_len,
  input  logic                      lsb,
  input  logic                      cpol,
  input  logic                      tx_neg,
  input  logic                      rx_neg,
  input  logic [div_w-1:0]          div,
  output logic                      busy,
  output logic                      done_pulse,
  output logic [63:0]               rx_bits,
  output logic                      sclk,
  output logic                      mosi,
  input  logic                      miso
);

  shift_state_t              state;
  logic [div_w-1:0]          div_cnt;
  logic [7:0]                edge_cnt;
  logic [ctl_char_len_w-1:0] len_in;
  logic [ctl_char_len_w-1:0] len_q;
  logic [ctl_char_len_w-1:0] tx_idx;
  logic [ctl_char_len_w-1:0] rx_idx;
  logic [63:0]               tx_q;
  logic [63:0]               rx_q;
  logic                      toggle;
  logic                      tx_edge;
  logic                      rx_edge;
  logic                      last_edge;

  // position of the idx-th bit on the wire
  function automatic logic [5:0] bit_pos(input logic [6:0] idx, input logic [6:0] len,
                                         input logic lsb_first);
    logic [6:0] pos;
    pos = lsb_first ? idx : len - 7'd1 - idx;
    return pos[5:0];
  endfunction

  assign len_in    = (char_len == '0) ? 7'd64 : char_len;
  assign toggle    = (state == sh_run) && (div_cnt == div);
  assign tx_edge   = toggle && (tx_neg ? sclk : !sclk);  // sclk high means falling next
  assign rx_edge   = toggle && (rx_neg ? sclk : !sclk);
  assign last_edge = toggle && (edge_cnt == {len_q, 1'b0} - 8'd1);
  assign busy       = (state != sh_idle);
  assign done_pulse = last_edge;

  // last sample lands on the same edge as done_pulse
  always_comb begin
    rx_bits = rx_q;
    if (rx_edge)
      rx_bits[bit_pos(rx_idx, len_q, lsb)] = miso;
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= sh_idle;
      div_cnt  <= '0;
      edge_cnt <= '0;
      len_q    <= 7'd64;
      tx_idx   <= '0;
      rx_idx   <= '0;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
    end else begin
      case (state)
        sh_idle: begin
          sclk    <= cpol;
          div_cnt <= '0;
          if (start) begin
            state    <= sh_run;
            len_q    <= len_in;
            edge_cnt <= '0;
            tx_idx   <= 7'd1;
            rx_idx   <= '0;
            mosi     <= tx_bits[bit_pos(7'd0, len_in, lsb)];  // first bit ahead of sclk
          end
        end
        sh_run: begin
          if (toggle) begin
            div_cnt  <= '0;
            sclk     <= !sclk;
            edge_cnt <= edge_cnt + 8'd1;
            if (tx_edge && (edge_cnt != 8'd0) && !last_edge) begin
              mosi   <= tx_q[bit_pos(tx_idx, len_q, lsb)];
              tx_idx <= tx_idx + 7'd1;
            end
            if (rx_edge)
              rx_idx <= rx_idx + 7'd1;
            if (last_edge)
              state <= sh_done;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: state <= sh_idle;  // one cycle of cs hold
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == sh_idle) && start) begin
      tx_q <= tx_bits;
      rx_q <= '0;
    end else if (rx_edge) begin
      rx_q <= rx_bits;
    end
  end

endmodule

`default_nettype wire

/* spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master
  import spi_pkg::*;
#(
  parameter int cs_num = 2
) (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic [rb_addr_w-1:0] rb_addr,
  input  logic                 rb_sel,
  input  logic                 rb_enable,
  input  logic                 rb_write,
  input  logic [data_w-1:0]    rb_wdata,
  output logic [data_w-1:0]    rb_rdata,
  output logic                 rb_ready,
  output logic                 rb_slverr,
  output logic                 irq,
  output logic                 spi_clk,
  output logic [cs_num-1:0]    spi_cs,
  output logic                 spi_mosi,
  input  logic                 spi_miso
);

  logic [data_w-1:0]         txd0;
  logic [data_w-1:0]         txd1;
  logic [data_w-1:0]         rxd0;
  logic [data_w-1:0]         rxd1;
  logic [ctl_char_len_w-1:0] char_len_q;
  logic                      rx_neg_q;
  logic                      tx_neg_q;
  logic                      lsb_q;
  logic                      ie_q;
  logic                      ass_q;
  logic                      rd_endian_q;
  logic                      cpol_q;
  logic [div_w-1:0]          div_q;
  logic [cs_num-1:0]         cs_q;
  logic                      start;
  logic                      busy;
  logic                      done_pulse;
  logic [63:0]               rx_bits;
  logic                      access;
  logic                      wr_en;
  logic                      rd_en;
  logic                      addr_ok;
  logic                      running;
  logic                      txd_hit;
  logic                      rxd_hit;

  assign access    = rb_sel && rb_enable;
  assign wr_en     = access && rb_write;
  assign rd_en     = access && !rb_write;
  assign running   = busy || start;  // go pending or shifting
  assign txd_hit   = (rb_addr == reg_txd0) || (rb_addr == reg_txd1);
  assign rxd_hit   = (rb_addr == reg_rxd0) || (rb_addr == reg_rxd1);
  assign rb_ready  = access;
  assign rb_slverr = access && (!addr_ok || (rb_write && running && txd_hit));

  always_comb begin
    rb_rdata = '0;
    addr_ok  = 1'b1;
    case (rb_addr)
      reg_rxd0: begin
        if (rd_endian_q)
          rb_rdata = {rxd0[7:0], rxd0[15:8], rxd0[23:16], rxd0[31:24]};
        else
          rb_rdata = rxd0;
      end
      reg_rxd1: rb_rdata = rxd1;
      reg_ctl: begin
        rb_rdata[ctl_char_len +: ctl_char_len_w] = char_len_q;
        rb_rdata[ctl_go]        = running;
        rb_rdata[ctl_rx_neg]    = rx_neg_q;
        rb_rdata[ctl_tx_neg]    = tx_neg_q;
        rb_rdata[ctl_lsb]       = lsb_q;
        rb_rdata[ctl_ie]        = ie_q;
        rb_rdata[ctl_ass]       = ass_q;
        rb_rdata[ctl_rd_endian] = rd_endian_q;
        rb_rdata[ctl_cpol]      = cpol_q;
      end
      reg_div: rb_rdata[div_w-1:0] = div_q;
      reg_cs:  rb_rdata[cs_num-1:0] = cs_q;
      default: addr_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      char_len_q  <= '0;
      rx_neg_q    <= 1'b0;
      tx_neg_q    <= 1'b0;
      lsb_q       <= 1'b0;
      ie_q        <= 1'b0;
      ass_q       <= 1'b0;
      rd_endian_q <= 1'b0;
      cpol_q      <= 1'b0;
      div_q       <= '0;
      cs_q        <= '0;
      start       <= 1'b0;
      irq         <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_en && (rb_addr == reg_ctl)) begin
        char_len_q  <= rb_wdata[ctl_char_len +: ctl_char_len_w];
        rx_neg_q    <= rb_wdata[ctl_rx_neg];
        tx_neg_q    <= rb_wdata[ctl_tx_neg];
        lsb_q       <= rb_wdata[ctl_lsb];
        ie_q        <= rb_wdata[ctl_ie];
        ass_q       <= rb_wdata[ctl_ass];
        rd_endian_q <= rb_wdata[ctl_rd_endian];
        cpol_q      <= rb_wdata[ctl_cpol];
        start       <= rb_wdata[ctl_go] && !running;  // go while busy is dropped
      end
      if (wr_en && (rb_addr == reg_div))
        div_q <= rb_wdata[div_w-1:0];
      if (wr_en && (rb_addr == reg_cs))
        cs_q <= rb_wdata[cs_num-1:0];
      if (done_pulse && ie_q)
        irq <= 1'b1;
      else if ((rd_en && rxd_hit) || (wr_en && (rb_addr == reg_ctl)))
        irq <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && !running && (rb_addr == reg_txd0))
      txd0 <= rb_wdata;
    if (wr_en && !running && (rb_addr == reg_txd1))
      txd1 <= rb_wdata;
    if (done_pulse) begin
      rxd0 <= rx_bits[31:0];
      rxd1 <= rx_bits[63:32];
    end
  end

  // auto mode selects only while shifting
  assign spi_cs = ~(cs_q & {cs_num{busy || !ass_q}});

  spi_shifter spi_shifter_i (
    .clk        (clk),
    .resetn     (resetn),
    .start      (start),
    .tx_bits    ({txd1, txd0}),
    .char_len   (char_len_q),
    .lsb        (lsb_q),
    .cpol       (cpol_q),
    .tx_neg     (tx_neg_q),
    .rx_neg     (rx_neg_q),
    .div        (div_q),
    .busy       (busy),
    .done_pulse (done_pulse),
    .rx_bits    (rx_bits),
    .sclk       (spi_clk),
    .mosi       (spi_mosi),
    .miso       (spi_miso)
  );

endmodule

`default_nettype wire

/* spi_flash_xip.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_flash_xip
  import spi_pkg::*;
#(
  parameter logic [addr_w-1:0] flash_addr_start = 32'h3000_0000,
  parameter logic [addr_w-1:0] flash_addr_end   = 32'h3fff_ffff
) (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic [addr_w-1:0]    paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [data_w-1:0]    pwdata,
  output logic                 pready,
  output logic [data_w-1:0]    prdata,
  output logic                 pslverr,
  output logic [rb_addr_w-1:0] rb_addr,
  output logic                 rb_sel,
  output logic                 rb_enable,
  output logic                 rb_write,
  output logic [data_w-1:0]    rb_wdata,
  input  logic [data_w-1:0]    rb_rdata,
  input  logic                 rb_ready,
  input  logic                 rb_slverr,
  input  logic                 irq,
  output logic                 spi_irq_out
);

  xip_state_t        state;
  xip_state_t        state_next;
  bus_phase_t        phase;
  logic [addr_w-1:0] paddr_align;
  logic [addr_w-1:0] addr_q;
  logic              win_hit;
  logic              apb_access;
  logic              win_wr_err;
  logic              rb_done;
  logic              issue_next;
  logic              answer;

  assign paddr_align = {paddr[addr_w-1:2], 2'b00};
  assign win_hit     = (paddr_align >= flash_addr_start) && (paddr_align <= flash_addr_end);
  assign apb_access  = psel && penable;
  assign win_wr_err  = (state == idle) && apb_access && win_hit && pwrite;  // flash is read only
  assign rb_done     = (phase == bus_access) && rb_ready;
  assign answer      = (state == csr) || (state == rd_rxd0);  // result goes back to apb
  assign issue_next  = (state_next != idle) && (state_next != wait_irq);

  always_ff @(posedge clk) begin
    if ((state == idle) && apb_access)
      addr_q <= paddr_align;
  end

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (apb_access && !(win_hit && pwrite))
          state_next = win_hit ? wr_txd1 : csr;
      end
      csr: begin
        if (rb_done)
          state_next = idle;
      end
      wr_txd1: begin
        if (rb_done)
          state_next = wr_txd0;
      end
      wr_txd0: begin
        if (rb_done)
          state_next = wr_cs;
      end
      wr_cs: begin
        if (rb_done)
          state_next = wr_ctl;
      end
      wr_ctl: begin
        if (rb_done)
          state_next = wait_irq;
      end
      wait_irq: begin
        if (irq)
          state_next = rd_rxd0;
      end
      default: begin
        if (rb_done)
          state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= idle;
      phase <= bus_idle;
    end else begin
      state <= state_next;
      case (phase)
        bus_idle: begin
          if (issue_next)
            phase <= bus_setup;
        end
        bus_setup: phase <= bus_access;
        default: begin
          if (rb_ready)
            phase <= issue_next ? bus_setup : bus_idle;  // chain next transaction
        end
      endcase
    end
  end

  always_comb begin
    rb_addr  = addr_q[rb_addr_w-1:0];
    rb_write = 1'b1;
    rb_wdata = '0;
    case (state)
      csr: begin
        rb_write = pwrite;
        rb_wdata = pwdata;
      end
      wr_txd1: begin
        rb_addr  = reg_txd1;
        rb_wdata = {flash_cmd_read, addr_q[23:0]};
      end
      wr_txd0: rb_addr = reg_txd0;  // dummy word clocks the data in
      wr_cs: begin
        rb_addr  = reg_cs;
        rb_wdata = data_w'(1);  // chip 0
      end
      wr_ctl: begin
        rb_addr  = reg_ctl;
        rb_wdata = xip_ctl_word;
      end
      rd_rxd0: begin
        rb_addr  = reg_rxd0;
        rb_write = 1'b0;
      end
      default: rb_write = 1'b0;
    endcase
  end

  assign rb_sel      = (phase != bus_idle);
  assign rb_enable   = (phase == bus_access);
  assign pready      = (answer && rb_done) || win_wr_err;
  assign pslverr     = (answer && rb_done && rb_slverr) || win_wr_err;
  assign prdata      = rb_rdata;
  assign spi_irq_out = irq && ((state == idle) || (state == csr));  // hidden during xip

endmodule

`default_nettype wire

/* spi_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_subsys
  import spi_pkg::*;
#(
  parameter logic [addr_w-1:0] flash_addr_start = 32'h3000_0000,
  parameter logic [addr_w-1:0] flash_addr_end   = 32'h3fff_ffff,
  parameter int                cs_num           = 2
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [addr_w-1:0]     paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic [2:0]            pprot,    // accepted, not decoded
  input  logic                  pwrite,
  input  logic [data_w-1:0]     pwdata,
  input  logic [data_w/8-1:0]   pstrb,    // full words only
  output logic                  pready,
  output logic [data_w-1:0]     prdata,
  output logic                  pslverr,
  output logic                  spi_clk,
  output logic [cs_num-1:0]     spi_cs,
  output logic                  spi_mosi,
  output logic                  spi_irq_out,
  input  logic                  spi_miso
);

  logic [rb_addr_w-1:0] rb_addr;
  logic                 rb_sel;
  logic                 rb_enable;
  logic                 rb_write;
  logic [data_w-1:0]    rb_wdata;
  logic [data_w-1:0]    rb_rdata;
  logic                 rb_ready;
  logic                 rb_slverr;
  logic                 irq;

  spi_flash_xip #(
    .flash_addr_start (flash_addr_start),
    .flash_addr_end   (flash_addr_end)
  ) spi_flash_xip_i (
    .clk         (clk),
    .resetn      (resetn),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .pready      (pready),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .rb_addr     (rb_addr),
    .rb_sel      (rb_sel),
    .rb_enable   (rb_enable),
    .rb_write    (rb_write),
    .rb_wdata    (rb_wdata),
    .rb_rdata    (rb_rdata),
    .rb_ready    (rb_ready),
    .rb_slverr   (rb_slverr),
    .irq         (irq),
    .spi_irq_out (spi_irq_out)
  );

  spi_master #(
    .cs_num (cs_num)
  ) spi_master_i (
    .clk       (clk),
    .resetn    (resetn),
    .rb_addr   (rb_addr),
    .rb_sel    (rb_sel),
    .rb_enable (rb_enable),
    .rb_write  (rb_write),
    .rb_wdata  (rb_wdata),
    .rb_rdata  (rb_rdata),
    .rb_ready  (rb_ready),
    .rb_slverr (rb_slverr),
    .irq       (irq),
    .spi_clk   (spi_clk),
    .spi_cs    (spi_cs),
    .spi_mosi  (spi_mosi),
    .spi_miso  (spi_miso)
  );

endmodule

`default_nettype wire

/* spi_flash_model.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  logic [31:0] cmd_addr;   // command byte then 24 bit address
  logic [7:0]  bit_cnt;    // rising edges since select
  logic [7:0]  data_idx;
  logic [23:0] byte_addr;
  logic [7:0]  data_byte;
  logic        read_cmd;

  function automatic logic [7:0] mem_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ 8'ha5;
  endfunction

  assign read_cmd  = (cmd_addr[31:24] == 8'h03) && (bit_cnt >= 8'd32);
  assign data_idx  = bit_cnt - 8'd32;
  assign byte_addr = cmd_addr[23:0] + {19'd0, data_idx[7:3]};  // successive bytes
  assign data_byte = mem_byte(byte_addr);

  // mode 0, mosi sampled on the rising edge
  always @(posedge sclk or posedge cs_n) begin
    if (cs_n) begin
      bit_cnt <= '0;
    end else begin
      if (bit_cnt < 8'd32)
        cmd_addr <= {cmd_addr[30:0], mosi};
      bit_cnt <= bit_cnt + 8'd1;
    end
  end

  // data msb first, changes on the falling edge
  always @(negedge sclk or posedge cs_n) begin
    if (cs_n)
      miso <= 1'b0;
    else if (read_cmd)
      miso <= data_byte[3'd7 - data_idx[2:0]];
    else
      miso <= 1'b0;
  end

endmodule

`default_nettype wire

/* tb_spi_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_subsys;

  localparam int          cs_num   = 2;
  localparam logic [31:0] flash_lo = 32'h3000_0000;
  localparam logic [31:0] off_rxd0 = 32'h0000_0000;
  localparam logic [31:0] off_txd0 = 32'h0000_0000;
  localparam logic [31:0] off_txd1 = 32'h0000_0004;
  localparam logic [31:0] off_ctl  = 32'h0000_0010;
  localparam logic [31:0] off_div  = 32'h0000_0014;
  localparam logic [31:0] off_cs   = 32'h0000_0018;
  localparam logic [31:0] off_bad  = 32'h0000_001c;
  // ie bit 12, ass bit 13, tx_neg bit 10, go bit 8
  localparam logic [31:0] ctl_sw   = 32'h0000_3400;
  localparam logic [31:0] ctl_go   = 32'h0000_0100;

  typedef enum int {k_xip, k_csr_wr, k_csr_rd, k_xfer, k_pins} kind_t;

  logic              clk;
  logic              resetn;
  logic [31:0]       paddr;
  logic              psel;
  logic              penable;
  logic [2:0]        pprot;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic [3:0]        pstrb;
  logic              pready;
  logic [31:0]       prdata;
  logic              pslverr;
  logic              spi_clk;
  logic [cs_num-1:0] spi_cs;
  logic              spi_mosi;
  logic              spi_irq_out;
  logic              spi_miso;

  kind_t       tab_kind[$];
  logic [31:0] tab_addr[$];
  logic [31:0] tab_wdata[$];
  logic [31:0] tab_exp[$];
  logic        tab_err[$];
  string       tab_name[$];

  int seed        = 57888;
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  spi_subsys #(
    .cs_num (cs_num)
  ) spi_subsys_i (
    .clk         (clk),
    .resetn      (resetn),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pprot       (pprot),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .pstrb       (pstrb),
    .pready      (pready),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .spi_clk     (spi_clk),
    .spi_cs      (spi_cs),
    .spi_mosi    (spi_mosi),
    .spi_irq_out (spi_irq_out),
    .spi_miso    (spi_miso)
  );

  spi_flash_model spi_flash_model_i (
    .sclk (spi_clk),
    .cs_n (spi_cs[0]),
    .mosi (spi_mosi),
    .miso (spi_miso)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit)) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [7:0] flash_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ 8'ha5;
  endfunction

  // word at the aligned address, first byte in the low lane
  function automatic logic [31:0] word_le(input logic [31:0] addr);
    logic [23:0] base;
    base = {addr[23:2], 2'b00};
    return {flash_byte(base + 24'd3), flash_byte(base + 24'd2),
            flash_byte(base + 24'd1), flash_byte(base)};
  endfunction

  function automatic logic [31:0] word_be(input logic [31:0] addr);
    logic [23:0] base;
    base = addr[23:0];
    return {flash_byte(base), flash_byte(base + 24'd1),
            flash_byte(base + 24'd2), flash_byte(base + 24'd3)};
  endfunction

  task automatic add_entry(input string name, input kind_t kind, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp,
                           input logic err);
    tab_name.push_back(name);
    tab_kind.push_back(kind);
    tab_addr.push_back(addr);
    tab_wdata.push_back(wdata);
    tab_exp.push_back(exp);
    tab_err.push_back(err);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic apb_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    #2;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready)
      @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_transfer(input string name, input logic [31:0] addr,
                              input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    logic        err_any;
    err_any = 1'b0;
    apb_access(1'b1, off_txd1, {8'h03, addr[23:0]}, rdata, err);
    err_any = err_any | err;
    apb_access(1'b1, off_txd0, 32'd0, rdata, err);
    err_any = err_any | err;
    apb_access(1'b1, off_cs, 32'd1, rdata, err);
    err_any = err_any | err;
    apb_access(1'b1, off_ctl, ctl_sw | ctl_go, rdata, err);
    err_any = err_any | err;
    check_value({name, " setup pslverr"}, 32'd0, {31'd0, err_any});
    while (!spi_irq_out)
      @(negedge clk);
    apb_access(1'b0, off_rxd0, 32'd0, rdata, err);
    check_value({name, " rxd0 pslverr"}, 32'd0, {31'd0, err});
    check_value(name, exp, rdata);
    @(negedge clk);
    check_value({name, " irq clear"}, 32'd0, {31'd0, spi_irq_out});
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          gap;
    resetn  = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pprot   = '0;
    pwrite  = 1'b0;
    pwdata  = '0;
    pstrb   = 4'hf;

    add_entry("xip base", k_xip, flash_lo, 0, word_le(flash_lo), 1'b0);
    add_entry("xip unaligned", k_xip, 32'h3000_0123, 0, word_le(32'h3000_0123), 1'b0);
    add_entry("div write", k_csr_wr, off_div, 32'd2, 0, 1'b0);
    add_entry("div read", k_csr_rd, off_div, 0, 32'd2, 1'b0);
    add_entry("xip div2", k_xip, 32'h3012_3456, 0, word_le(32'h3012_3456), 1'b0);
    add_entry("xip top", k_xip, 32'h3fff_fffd, 0, word_le(32'h3fff_fffd), 1'b0);
    add_entry("div zero", k_csr_wr, off_div, 32'd0, 0, 1'b0);
    add_entry("sw transfer", k_xfer, 32'h0000_0a40, 0, word_be(32'h0000_0a40), 1'b0);
    add_entry("ctl after go", k_csr_rd, off_ctl, 0, ctl_sw, 1'b0);
    add_entry("cs write", k_csr_wr, off_cs, 32'd2, 0, 1'b0);
    add_entry("cs read", k_csr_rd, off_cs, 0, 32'd2, 1'b0);
    add_entry("ctl manual", k_csr_wr, off_ctl, 32'h0000_0a20, 0, 1'b0);
    add_entry("ctl read", k_csr_rd, off_ctl, 0, 32'h0000_0a20, 1'b0);
    add_entry("manual cs pins", k_pins, 0, 0, 32'h0000_0001, 1'b0);
    add_entry("flash write", k_csr_wr, 32'h3000_0010, 32'h1234_5678, 0, 1'b1);
    add_entry("bad offset read", k_csr_rd, off_bad, 0, 0, 1'b1);
    add_entry("bad offset write", k_csr_wr, off_bad, 32'h5a5a_5a5a, 0, 1'b1);
    add_entry("xip after manual", k_xip, 32'h3000_7777, 0, word_le(32'h3000_7777), 1'b0);
    add_entry("cs from xip", k_csr_rd, off_cs, 0, 32'd1, 1'b0);
    cycle_limit = tab_kind.size() * 600;

    repeat (16) @(posedge clk);
    #2;
    resetn = 1'b1;
    @(negedge clk);
    check_value("reset pready", 32'd0, {31'd0, pready});
    check_value("reset pslverr", 32'd0, {31'd0, pslverr});
    check_value("reset irq", 32'd0, {31'd0, spi_irq_out});
    check_value("reset cs", 32'd3, {30'd0, spi_cs});
    check_value("reset sclk", 32'd0, {31'd0, spi_clk});

    for (int i = 0; i < tab_kind.size(); i++) begin
      gap = $random(seed) & 7;  // idle cycles between entries
      repeat (gap) @(posedge clk);
      case (tab_kind[i])
        k_xip, k_csr_rd: begin
          apb_access(1'b0, tab_addr[i], 32'd0, rdata, err);
          check_value({tab_name[i], " pslverr"}, {31'd0, tab_err[i]}, {31'd0, err});
          if (!tab_err[i])
            check_value(tab_name[i], tab_exp[i], rdata);
        end
        k_csr_wr: begin
          apb_access(1'b1, tab_addr[i], tab_wdata[i], rdata, err);
          check_value({tab_name[i], " pslverr"}, {31'd0, tab_err[i]}, {31'd0, err});
        end
        k_xfer: run_transfer(tab_name[i], tab_addr[i], tab_exp[i]);
        default: begin
          @(negedge clk);
          check_value(tab_name[i], tab_exp[i], {30'd0, spi_cs});
        end
      endcase
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
spi_pkg.sv
spi_shifter.sv
spi_master.sv
spi_flash_xip.sv
spi_subsys.sv
spi_flash_model.sv
tb_spi_subsys.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_spi_subsys -f build.f -o tb_spi_subsys_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_spi_subsys_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
